/* all.f */
+incdir+design
design/ros2_glue_pkg.sv
design/byte_fifo.sv
design/buffer_ownership_arbiter.sv
design/ros2_ether_glue.sv
tb/tb_clock_gen.sv
tb/tb_ros2_ether_glue.sv

/* design/buffer_ownership_arbiter.sv */
`timescale 1ns/10ps
`default_nettype none

module buffer_ownership_arbiter (
  input  wire  clk,
  input  wire  rst_n,
  input  wire  i_ether_en,

  input  wire  i_app_eng_req,
  input  wire  i_app_eng_rel,
  input  wire  i_app_cpu_req,
  input  wire  i_app_cpu_rel,
  output logic o_app_eng_grant,
  output logic o_app_cpu_grant,

  input  wire  i_rxbuf_eng_rel,
  input  wire  i_rxbuf_cpu_rel,
  output logic o_rxbuf_eng_grant,
  output logic o_rxbuf_cpu_grant,

  input  wire  i_txbuf_eng_rel,
  input  wire  i_txbuf_cpu_rel,
  output logic o_txbuf_eng_grant,
  output logic o_txbuf_cpu_grant
);

  ros2_glue_pkg::app_grant_e app_state;
  ros2_glue_pkg::buf_owner_e rxbuf_owner;
  ros2_glue_pkg::buf_owner_e txbuf_owner;

  // Only the current owner can hand a buffer over.
  function automatic ros2_glue_pkg::buf_owner_e next_owner(
    input ros2_glue_pkg::buf_owner_e owner,
    input logic                      eng_rel,
    input logic                      cpu_rel
  );
    ros2_glue_pkg::buf_owner_e next;
    next = owner;
    if (owner == ros2_glue_pkg::BUF_ENGINE && eng_rel) begin
      next = ros2_glue_pkg::BUF_CPU;
    end else if (owner == ros2_glue_pkg::BUF_CPU && cpu_rel) begin
      next = ros2_glue_pkg::BUF_ENGINE;
    end
    return next;
  endfunction

  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      app_state <= ros2_glue_pkg::APP_NONE;
    end else begin
      case (app_state)
        ros2_glue_pkg::APP_NONE: begin
          if (i_app_eng_req) begin
            app_state <= ros2_glue_pkg::APP_ENGINE; // The engine wins a tie.
          end else if (i_app_cpu_req) begin
            app_state <= ros2_glue_pkg::APP_CPU;
          end
        end
        ros2_glue_pkg::APP_ENGINE: begin
          if (i_app_eng_rel) begin
            app_state <= ros2_glue_pkg::APP_NONE;
          end
        end
        ros2_glue_pkg::APP_CPU: begin
          if (i_app_cpu_rel) begin
            app_state <= ros2_glue_pkg::APP_NONE;
          end
        end
        default: app_state <= ros2_glue_pkg::APP_NONE;
      endcase
    end
  end

  // The engine starts out filling the RX buffer and the CPU the TX buffer.
  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      rxbuf_owner <= ros2_glue_pkg::BUF_ENGINE;
      txbuf_owner <= ros2_glue_pkg::BUF_CPU;
    end else begin
      rxbuf_owner <= next_owner(rxbuf_owner, i_rxbuf_eng_rel, i_rxbuf_cpu_rel);
      txbuf_owner <= next_owner(txbuf_owner, i_txbuf_eng_rel, i_txbuf_cpu_rel);
    end
  end

  // The state machines keep running while disabled. Only the grants are masked.
  assign o_app_eng_grant = i_ether_en & (app_state == ros2_glue_pkg::APP_ENGINE);
  assign o_app_cpu_grant = i_ether_en & (app_state == ros2_glue_pkg::APP_CPU);

  assign o_rxbuf_eng_grant = i_ether_en & (rxbuf_owner == ros2_glue_pkg::BUF_ENGINE);
  assign o_rxbuf_cpu_grant = i_ether_en & (rxbuf_owner == ros2_glue_pkg::BUF_CPU);
  assign o_txbuf_eng_grant = i_ether_en & (txbuf_owner == ros2_glue_pkg::BUF_ENGINE);
  assign o_txbuf_cpu_grant = i_ether_en & (txbuf_owner == ros2_glue_pkg::BUF_CPU);

  a_app_exclusive: assert property (@(posedge clk) disable iff (!rst_n)
    !(o_app_eng_grant && o_app_cpu_grant))
    else $error("Both sides hold the application data.");

  a_rxbuf_one_owner: assert property (@(posedge clk) disable iff (!rst_n)
    i_ether_en |-> (o_rxbuf_eng_grant ^ o_rxbuf_cpu_grant))
    else $error("UDP RX buffer does not have exactly one owner.");

  a_txbuf_one_owner: assert property (@(posedge clk) disable iff (!rst_n)
    i_ether_en |-> (o_txbuf_eng_grant ^ o_txbuf_cpu_grant))
    else $error("UDP TX buffer does not have exactly one owner.");

endmodule

`default_nettype wire

/* design/byte_fifo.sv */
`timescale 1ns/10ps
`default_nettype none

`include "ros2_glue_params.svh"

module byte_fifo #(
  parameter int DEPTH = 16
) (
  input  wire                     clk,
  input  wire                     rst_n,
  input  wire                     i_wr_en,
  input  wire [`ROS2_BYTE_W-1:0]  i_din,
  output logic                    o_full,
  input  wire                     i_rd_en,
  output logic [`ROS2_BYTE_W-1:0] o_dout,
  output logic                    o_empty
);

  localparam int AW = (DEPTH > 1) ? $clog2(DEPTH) : 1;
  localparam logic [AW:0] FULL_COUNT = (AW + 1)'(DEPTH);
  localparam logic [AW-1:0] LAST_ADDR = AW'(DEPTH - 1);

  logic [`ROS2_BYTE_W-1:0] mem [DEPTH];
  logic [AW-1:0]           wr_ptr;
  logic [AW-1:0]           rd_ptr;
  logic [AW:0]             count;
  logic                    wr_ok;
  logic                    rd_ok;

  assign wr_ok = i_wr_en & ~o_full;   // Writes into a full FIFO are dropped.
  assign rd_ok = i_rd_en & ~o_empty;
  assign o_full = (count == FULL_COUNT);
  assign o_empty = (count == '0);

  // The head byte is always on the output, so a read just advances the pointer.
  assign o_dout = mem[rd_ptr];

  always_ff @(posedge clk) begin
    if (wr_ok) begin
      mem[wr_ptr] <= i_din;
    end
  end

  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      wr_ptr <= '0;
      rd_ptr <= '0;
      count  <= '0;
    end else begin
      if (wr_ok) begin
        wr_ptr <= (wr_ptr == LAST_ADDR) ? '0 : wr_ptr + 1'b1;
      end
      if (rd_ok) begin
        rd_ptr <= (rd_ptr == LAST_ADDR) ? '0 : rd_ptr + 1'b1;
      end
      case ({wr_ok, rd_ok})
        2'b10:   count <= count + 1'b1;
        2'b01:   count <= count - 1'b1;
        default: count <= count;       // Idle, or a read and a write together.
      endcase
    end
  end

  a_count_bound: assert property (@(posedge clk) disable iff (!rst_n)
    count <= FULL_COUNT)
    else $error("byte_fifo occupancy above DEPTH.");

endmodule

`default_nettype wire

/* design/ros2_ether_glue.sv */
`timescale 1ns/10ps
`default_nettype none

`include "ros2_glue_params.svh"

module ros2_ether_glue (
  input  wire                     clk,
  input  wire                     rst_n,
  input  wire                     i_ether_en,

  input  wire [47:0]              i_mac_addr,
  input  wire [31:0]              i_ip_addr,
  input  wire [31:0]              i_gateway_ip_addr,
  input  wire [31:0]              i_subnet_mask,
  output logic [47:0]             o_net_mac,
  output logic [31:0]             o_net_ip,
  output logic [31:0]             o_net_gateway_ip,
  output logic [31:0]             o_net_subnet_mask,

  input  wire                     i_app_eng_req,
  input  wire                     i_app_eng_rel,
  input  wire                     i_app_cpu_req,
  input  wire                     i_app_cpu_rel,
  output logic                    o_app_eng_grant,
  output logic                    o_app_cpu_grant,
  input  wire                     i_rxbuf_eng_rel,
  input  wire                     i_rxbuf_cpu_rel,
  output logic                    o_rxbuf_eng_grant,
  output logic                    o_rxbuf_cpu_grant,
  input  wire                     i_txbuf_eng_rel,
  input  wire                     i_txbuf_cpu_rel,
  output logic                    o_txbuf_eng_grant,
  output logic                    o_txbuf_cpu_grant,

  input  wire                     i_tx_wr_en,
  input  wire [`ROS2_BYTE_W-1:0]  i_tx_din,
  input  wire                     i_tx_rd_en,
  output logic                    o_tx_full,
  output logic [`ROS2_BYTE_W-1:0] o_tx_dout,
  output logic                    o_tx_empty,

  input  wire                     i_rx_wr_en,
  input  wire [`ROS2_BYTE_W-1:0]  i_rx_din,
  input  wire                     i_rx_rd_en,
  output logic                    o_rx_full,
  output logic [`ROS2_BYTE_W-1:0] o_rx_dout,
  output logic                    o_rx_empty
);

  ros2_glue_pkg::mac_addr_u  mac_net;
  ros2_glue_pkg::ipv4_addr_u ip_net;
  ros2_glue_pkg::ipv4_addr_u gateway_net;
  ros2_glue_pkg::ipv4_addr_u subnet_net;

  // Network order puts the most significant host byte first on the wire.
  function automatic ros2_glue_pkg::ipv4_addr_u swap_ipv4(
    input ros2_glue_pkg::ipv4_addr_u host
  );
    ros2_glue_pkg::ipv4_addr_u net;
    for (int i = 0; i < 4; i++) begin
      net.bytes[i] = host.bytes[3 - i];
    end
    return net;
  endfunction

  function automatic ros2_glue_pkg::mac_addr_u swap_mac(
    input ros2_glue_pkg::mac_addr_u host
  );
    ros2_glue_pkg::mac_addr_u net;
    for (int i = 0; i < 6; i++) begin
      net.bytes[i] = host.bytes[5 - i];
    end
    return net;
  endfunction

  assign mac_net     = swap_mac(i_mac_addr);
  assign ip_net      = swap_ipv4(i_ip_addr);
  assign gateway_net = swap_ipv4(i_gateway_ip_addr);
  assign subnet_net  = swap_ipv4(i_subnet_mask);

  // The stack sees all-zero addresses while Ethernet is off.
  assign o_net_mac         = i_ether_en ? mac_net.word : '0;
  assign o_net_ip          = i_ether_en ? ip_net.word : '0;
  assign o_net_gateway_ip  = i_ether_en ? gateway_net.word : '0;
  assign o_net_subnet_mask = i_ether_en ? subnet_net.word : '0;

  buffer_ownership_arbiter u_arbiter (
    .clk               (clk),
    .rst_n             (rst_n),
    .i_ether_en        (i_ether_en),
    .i_app_eng_req     (i_app_eng_req),
    .i_app_eng_rel     (i_app_eng_rel),
    .i_app_cpu_req     (i_app_cpu_req),
    .i_app_cpu_rel     (i_app_cpu_rel),
    .o_app_eng_grant   (o_app_eng_grant),
    .o_app_cpu_grant   (o_app_cpu_grant),
    .i_rxbuf_eng_rel   (i_rxbuf_eng_rel),
    .i_rxbuf_cpu_rel   (i_rxbuf_cpu_rel),
    .o_rxbuf_eng_grant (o_rxbuf_eng_grant),
    .o_rxbuf_cpu_grant (o_rxbuf_cpu_grant),
    .i_txbuf_eng_rel   (i_txbuf_eng_rel),
    .i_txbuf_cpu_rel   (i_txbuf_cpu_rel),
    .o_txbuf_eng_grant (o_txbuf_eng_grant),
    .o_txbuf_cpu_grant (o_txbuf_cpu_grant)
  );

  // Engine writes, network side reads.
  byte_fifo #(
    .DEPTH (`ROS2_TX_FIFO_DEPTH)
  ) u_tx_fifo (
    .clk     (clk),
    .rst_n   (rst_n),
    .i_wr_en (i_tx_wr_en),
    .i_din   (i_tx_din),
    .o_full  (o_tx_full),
    .i_rd_en (i_tx_rd_en),
    .o_dout  (o_tx_dout),
    .o_empty (o_tx_empty)
  );

  byte_fifo #(
    .DEPTH (`ROS2_RX_FIFO_DEPTH)
  ) u_rx_fifo (
    .clk     (clk),
    .rst_n   (rst_n),
    .i_wr_en (i_rx_wr_en),
    .i_din   (i_rx_din),
    .o_full  (o_rx_full),
    .i_rd_en (i_rx_rd_en),
    .o_dout  (o_rx_dout),
    .o_empty (o_rx_empty)
  );

endmodule

`default_nettype wire

/* design/ros2_glue_params.svh */
`ifndef ROS2_GLUE_PARAMS_SVH
`define ROS2_GLUE_PARAMS_SVH

// Width of one byte on the engine and network streams.
`define ROS2_BYTE_W 8

// Engine to network direction.
`define ROS2_TX_FIFO_DEPTH 16

// Network to engine direction.
`define ROS2_RX_FIFO_DEPTH 16

`endif

/* design/ros2_glue_pkg.sv */
`default_nettype none

`include "ros2_glue_params.svh"

package ros2_glue_pkg;

  // Owner of the application data registers.
  typedef enum logic [1:0] {
    APP_NONE   = 2'b00,
    APP_ENGINE = 2'b01,
    APP_CPU    = 2'b10
  } app_grant_e;

  // Owner of a UDP buffer. One side always holds it.
  typedef enum logic {
    BUF_ENGINE = 1'b0,
    BUF_CPU    = 1'b1
  } buf_owner_e;

  typedef union packed {
    logic [31:0]                  word;  // Host order.
    logic [3:0][`ROS2_BYTE_W-1:0] bytes; // Byte 0 is the least significant.
  } ipv4_addr_u;

  typedef union packed {
    logic [47:0]                  word;
    logic [5:0][`ROS2_BYTE_W-1:0] bytes;
  } mac_addr_u;

endpackage

`default_nettype wire

/* run.sh */
#!/bin/sh
# Builds the testbench with Verilator and runs it from the project root.

cd "$(dirname "$0")" || exit 1

TOP=tb_ros2_ether_glue
OBJ=obj_dir

if ! verilator --binary --timing --assert -Wno-fatal --timescale 1ns/10ps \
    --top-module "$TOP" -Mdir "$OBJ" -f all.f; then
  echo "Verilator build failed."
  exit 1
fi

output=$("./$OBJ/V$TOP" 2>&1)
status=$?
printf '%s\n' "$output"

if [ "$status" -ne 0 ]; then
  echo "Simulation exited with status $status."
  exit 1
fi

if printf '%s\n' "$output" | grep -qx "TB PASSED"; then
  exit 0
fi

echo "Pass message not found in the simulation output."
exit 1

/* tb/tb_clock_gen.sv */
`timescale 1ns/10ps
`default_nettype none

module tb_clock_gen #(
  parameter int PERIOD_NS    = 100,
  parameter int RESET_CYCLES = 8
) (
  output logic clk,
  output logic rst_n
);

  initial begin
    clk = 1'b0;
    forever #(PERIOD_NS / 2) clk = ~clk;
  end

  // Reset lets go just after a rising edge, at the same offset as the stimulus.
  initial begin
    rst_n = 1'b0;
    repeat (RESET_CYCLES) @(posedge clk);
    #(PERIOD_NS / 10) rst_n = 1'b1;
  end

endmodule

`default_nettype wire

/* tb/tb_ros2_ether_glue.sv */
`timescale 1ns/10ps
`default_nettype none

`include "ros2_glue_params.svh"

module tb_ros2_ether_glue;

  localparam int CLK_PERIOD   = 100;
  localparam int RESET_CYCLES = 8;
  localparam int N_ARB        = 300;
  localparam int N_BUF        = 100;
  localparam int N_EN         = 40;
  localparam int N_FIFO       = 200;
  localparam int N_ADDR       = 30;
  localparam int TOTAL_CYCLES = RESET_CYCLES + N_ARB + N_BUF + N_EN + N_FIFO + N_ADDR
                              + 4 * (`ROS2_TX_FIFO_DEPTH + `ROS2_RX_FIFO_DEPTH) + 40;

  wire clk;
  wire rst_n;
  logic i_ether_en;
  logic [47:0] i_mac_addr;
  logic [31:0] i_ip_addr, i_gateway_ip_addr, i_subnet_mask;
  logic i_app_eng_req, i_app_eng_rel, i_app_cpu_req, i_app_cpu_rel;
  logic i_rxbuf_eng_rel, i_rxbuf_cpu_rel, i_txbuf_eng_rel, i_txbuf_cpu_rel;
  logic i_tx_wr_en, i_tx_rd_en, i_rx_wr_en, i_rx_rd_en;
  logic [`ROS2_BYTE_W-1:0] i_tx_din, i_rx_din;
  wire [47:0] o_net_mac;
  wire [31:0] o_net_ip, o_net_gateway_ip, o_net_subnet_mask;
  wire o_app_eng_grant, o_app_cpu_grant;
  wire o_rxbuf_eng_grant, o_rxbuf_cpu_grant, o_txbuf_eng_grant, o_txbuf_cpu_grant;
  wire o_tx_full, o_tx_empty, o_rx_full, o_rx_empty;
  wire [`ROS2_BYTE_W-1:0] o_tx_dout, o_rx_dout;

  logic [3:0] arb_m;                          // {app state, RX owner, TX owner}.
  logic [`ROS2_BYTE_W-1:0] tx_q[$];
  logic [`ROS2_BYTE_W-1:0] rx_q[$];
  logic tx_wr, tx_rd, rx_wr, rx_rd;
  logic [31:0] rnd;
  logic [`ROS2_BYTE_W-1:0] last_byte;
  int checks = 0;
  int errors = 0;
  int errors_seen = 0;
  int tests = 0;

  tb_clock_gen #(.PERIOD_NS(CLK_PERIOD), .RESET_CYCLES(RESET_CYCLES)) u_clock_gen (
    .clk   (clk),
    .rst_n (rst_n)
  );

  ros2_ether_glue u_ros2_ether_glue (.*);

  function automatic logic [31:0] xorshift32(input logic [31:0] x);
    logic [31:0] y;
    y = x ^ (x << 13);
    y = y ^ (y >> 17);
    y = y ^ (y << 5);
    return y;
  endfunction

  // Next arbiter state from the ownership rules. Release pairs are {cpu, engine}.
  function automatic logic [3:0] arbiter_model(
    input logic [3:0] cur,
    input logic       eng_req,
    input logic       eng_rel,
    input logic       cpu_req,
    input logic       cpu_rel,
    input logic [1:0] rx_rel,
    input logic [1:0] tx_rel
  );
    logic [1:0] app;
    logic       rx;
    logic       tx;
    app = cur[3:2];
    rx  = cur[1];
    tx  = cur[0];
    if (app == ros2_glue_pkg::APP_NONE) begin
      if (eng_req) begin
        app = ros2_glue_pkg::APP_ENGINE;
      end else if (cpu_req) begin
        app = ros2_glue_pkg::APP_CPU;
      end
    end else if ((app == ros2_glue_pkg::APP_ENGINE) ? eng_rel : cpu_rel) begin
      app = ros2_glue_pkg::APP_NONE;
    end
    if ((rx == ros2_glue_pkg::BUF_ENGINE) ? rx_rel[0] : rx_rel[1]) rx = ~rx;
    if ((tx == ros2_glue_pkg::BUF_ENGINE) ? tx_rel[0] : tx_rel[1]) tx = ~tx;
    return {app, rx, tx};
  endfunction

  // The first byte on the wire is the most significant host byte.
  function automatic logic [47:0] net_order(
    input logic [47:0] host,
    input int          nbytes,
    input logic        en
  );
    logic [47:0] net;
    net = '0;
    for (int i = 0; i < nbytes; i++) begin
      net[`ROS2_BYTE_W*i +: `ROS2_BYTE_W] = host[`ROS2_BYTE_W*(nbytes-1-i) +: `ROS2_BYTE_W];
    end
    return en ? net : 48'd0;
  endfunction

  task automatic expect_equal(input string what, input logic [47:0] got,
                              input logic [47:0] exp);
    checks++;
    assert (got === exp) else begin
      errors++;
      $display("FAILED %0t: %s is %h, expected %h", $time, what, got, exp);
    end
  endtask

  task automatic next_cycle();
    @(posedge clk);
    #10;
  endtask

  task automatic report_test(input string name);
    tests++;
    $display("Test %-12s done with %0d errors.", name, errors - errors_seen);
    errors_seen = errors;
  endtask

  task automatic drive_random_addresses();
    rnd = xorshift32(rnd);
    i_ip_addr = rnd;
    rnd = xorshift32(rnd);
    i_gateway_ip_addr = rnd;
    rnd = xorshift32(rnd);
    i_subnet_mask = rnd;
    rnd = xorshift32(rnd);
    i_mac_addr[47:32] = rnd[15:0];
    rnd = xorshift32(rnd);
    i_mac_addr[31:0] = rnd;
  endtask

  always @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      arb_m = {ros2_glue_pkg::APP_NONE, ros2_glue_pkg::BUF_ENGINE, ros2_glue_pkg::BUF_CPU};
      tx_q.delete();
      rx_q.delete();
    end else begin
      arb_m = arbiter_model(arb_m, i_app_eng_req, i_app_eng_rel, i_app_cpu_req,
                            i_app_cpu_rel, {i_rxbuf_cpu_rel, i_rxbuf_eng_rel},
                            {i_txbuf_cpu_rel, i_txbuf_eng_rel});
      tx_wr = i_tx_wr_en && tx_q.size() < `ROS2_TX_FIFO_DEPTH;
      tx_rd = i_tx_rd_en && tx_q.size() > 0;
      rx_wr = i_rx_wr_en && rx_q.size() < `ROS2_RX_FIFO_DEPTH;
      rx_rd = i_rx_rd_en && rx_q.size() > 0;
      if (tx_rd) void'(tx_q.pop_front());
      if (tx_wr) tx_q.push_back(i_tx_din);
      if (rx_rd) void'(rx_q.pop_front());
      if (rx_wr) rx_q.push_back(i_rx_din);
    end
  end

  // Mid-cycle compare, where inputs and registered outputs are both settled.
  always @(negedge clk) begin
    if (rst_n) begin
      expect_equal("o_app_eng_grant", o_app_eng_grant,
                   i_ether_en && arb_m[3:2] == ros2_glue_pkg::APP_ENGINE);
      expect_equal("o_app_cpu_grant", o_app_cpu_grant,
                   i_ether_en && arb_m[3:2] == ros2_glue_pkg::APP_CPU);
      expect_equal("o_rxbuf_eng_grant", o_rxbuf_eng_grant, i_ether_en && !arb_m[1]);
      expect_equal("o_rxbuf_cpu_grant", o_rxbuf_cpu_grant, i_ether_en && arb_m[1]);
      expect_equal("o_txbuf_eng_grant", o_txbuf_eng_grant, i_ether_en && !arb_m[0]);
      expect_equal("o_txbuf_cpu_grant", o_txbuf_cpu_grant, i_ether_en && arb_m[0]);
      expect_equal("o_net_mac", o_net_mac, net_order(i_mac_addr, 6, i_ether_en));
      expect_equal("o_net_ip", o_net_ip, net_order(i_ip_addr, 4, i_ether_en));
      expect_equal("o_net_gateway_ip", o_net_gateway_ip,
                   net_order(i_gateway_ip_addr, 4, i_ether_en));
      expect_equal("o_net_subnet_mask", o_net_subnet_mask,
                   net_order(i_subnet_mask, 4, i_ether_en));
      expect_equal("o_tx_empty", o_tx_empty, tx_q.size() == 0);
      expect_equal("o_tx_full", o_tx_full, tx_q.size() == `ROS2_TX_FIFO_DEPTH);
      expect_equal("o_rx_empty", o_rx_empty, rx_q.size() == 0);
      expect_equal("o_rx_full", o_rx_full, rx_q.size() == `ROS2_RX_FIFO_DEPTH);
      if (tx_q.size() > 0) expect_equal("o_tx_dout", o_tx_dout, tx_q[0]);
      if (rx_q.size() > 0) expect_equal("o_rx_dout", o_rx_dout, rx_q[0]);
    end
  end

  initial begin
    #(TOTAL_CYCLES * 2 * CLK_PERIOD);
    $display("Watchdog expired before the tests completed.");
    $display("TB FAILED");
    $finish;
  end

  initial begin
    rnd = 32'd24164;
    i_ether_en = 1'b1;
    {i_mac_addr, i_ip_addr, i_gateway_ip_addr, i_subnet_mask} = '0;
    {i_app_eng_req, i_app_eng_rel, i_app_cpu_req, i_app_cpu_rel} = '0;
    {i_rxbuf_eng_rel, i_rxbuf_cpu_rel, i_txbuf_eng_rel, i_txbuf_cpu_rel} = '0;
    {i_tx_wr_en, i_tx_rd_en, i_rx_wr_en, i_rx_rd_en} = '0;
    i_tx_din = '0;
    i_rx_din = '0;
    @(posedge rst_n);

    expect_equal("app grants after reset", {o_app_eng_grant, o_app_cpu_grant}, 2'b00);
    expect_equal("RX buffer grants after reset", {o_rxbuf_eng_grant, o_rxbuf_cpu_grant}, 2'b10);
    expect_equal("TX buffer grants after reset", {o_txbuf_eng_grant, o_txbuf_cpu_grant}, 2'b01);
    expect_equal("FIFO empty flags after reset", {o_tx_empty, o_rx_empty}, 2'b11);
    report_test("reset");

    {i_app_eng_req, i_app_cpu_req} = 2'b11;    // A tie from idle goes to the engine.
    next_cycle();
    expect_equal("tie grants", {o_app_eng_grant, o_app_cpu_grant}, 2'b10);
    {i_app_eng_req, i_app_cpu_req, i_app_eng_rel} = 3'b001;
    next_cycle();
    for (int i = 0; i < N_ARB; i++) begin
      rnd = xorshift32(rnd);
      i_app_eng_req = rnd[0];
      i_app_cpu_req = rnd[1];
      i_app_eng_rel = rnd[2] & rnd[3];
      i_app_cpu_rel = rnd[4] & rnd[5];
      next_cycle();
    end
    {i_app_eng_req, i_app_eng_rel, i_app_cpu_req, i_app_cpu_rel} = '0;
    report_test("app_arbiter");

    {i_rxbuf_cpu_rel, i_txbuf_eng_rel} = 2'b11;  // Releases from the non-owners.
    next_cycle();
    expect_equal("RX buffer after CPU release", {o_rxbuf_eng_grant, o_rxbuf_cpu_grant}, 2'b10);
    expect_equal("TX buffer after engine release", {o_txbuf_eng_grant, o_txbuf_cpu_grant}, 2'b01);
    {i_rxbuf_cpu_rel, i_txbuf_eng_rel, i_rxbuf_eng_rel, i_txbuf_cpu_rel} = 4'b0011;
    next_cycle();
    expect_equal("RX buffer after engine release", {o_rxbuf_eng_grant, o_rxbuf_cpu_grant}, 2'b01);
    expect_equal("TX buffer after CPU release", {o_txbuf_eng_grant, o_txbuf_cpu_grant}, 2'b10);
    for (int i = 0; i < N_BUF; i++) begin
      rnd = xorshift32(rnd);
      {i_rxbuf_eng_rel, i_rxbuf_cpu_rel, i_txbuf_eng_rel, i_txbuf_cpu_rel} = rnd[3:0] & rnd[7:4];
      next_cycle();
    end
    {i_rxbuf_eng_rel, i_rxbuf_cpu_rel, i_txbuf_eng_rel, i_txbuf_cpu_rel} = '0;
    report_test("buffer");

    i_ether_en = 1'b0;
    for (int i = 0; i < N_EN; i++) begin
      drive_random_addresses();
      rnd = xorshift32(rnd);
      {i_app_eng_req, i_app_cpu_req} = rnd[1:0];
      {i_app_eng_rel, i_app_cpu_rel} = rnd[3:2] & rnd[5:4];
      {i_rxbuf_eng_rel, i_rxbuf_cpu_rel, i_txbuf_eng_rel, i_txbuf_cpu_rel} = rnd[9:6] & rnd[13:10];
      next_cycle();
    end
    expect_equal("grants while disabled", {o_app_eng_grant, o_app_cpu_grant, o_rxbuf_eng_grant,
                 o_rxbuf_cpu_grant, o_txbuf_eng_grant, o_txbuf_cpu_grant}, 6'b0);
    expect_equal("o_net_mac while disabled", o_net_mac, 48'd0);
    {i_app_eng_req, i_app_eng_rel, i_app_cpu_req, i_app_cpu_rel} = '0;
    {i_rxbuf_eng_rel, i_rxbuf_cpu_rel, i_txbuf_eng_rel, i_txbuf_cpu_rel} = '0;
    i_ether_en = 1'b1;
    next_cycle();
    expect_equal("RX engine grant after enable", o_rxbuf_eng_grant, !arb_m[1]);
    report_test("enable");

    for (int i = 0; i < `ROS2_TX_FIFO_DEPTH + 3; i++) begin
      rnd = xorshift32(rnd);
      i_tx_wr_en = 1'b1;
      i_tx_din = rnd[7:0];
      next_cycle();
    end
    i_tx_wr_en = 1'b0;
    expect_equal("o_tx_full after overfill", o_tx_full, 1'b1);
    i_tx_rd_en = 1'b1;
    while (!o_tx_empty) next_cycle();
    repeat (3) next_cycle();                   // Reads into an empty FIFO.
    i_tx_rd_en = 1'b0;
    expect_equal("o_tx_empty after drain", o_tx_empty, 1'b1);
    rnd = xorshift32(rnd);
    last_byte = rnd[7:0];
    i_tx_wr_en = 1'b1;
    i_tx_din = last_byte;
    next_cycle();
    i_tx_wr_en = 1'b0;
    expect_equal("o_tx_dout after empty reads", o_tx_dout, last_byte);
    i_tx_rd_en = 1'b1;
    next_cycle();
    i_tx_rd_en = 1'b0;
    for (int i = 0; i < N_FIFO; i++) begin
      rnd = xorshift32(rnd);
      i_rx_wr_en = rnd[0] | rnd[1];
      i_rx_rd_en = rnd[2];
      i_rx_din = rnd[15:8];
      next_cycle();
    end
    i_rx_wr_en = 1'b0;
    i_rx_rd_en = 1'b1;
    while (!o_rx_empty) next_cycle();
    i_rx_rd_en = 1'b0;
    report_test("fifo");

    i_mac_addr = 48'h0011_2233_4455;
    i_ip_addr = 32'hC0A8_0001;
    next_cycle();
    expect_equal("o_net_mac known value", o_net_mac, 48'h5544_3322_1100);
    expect_equal("o_net_ip known value", o_net_ip, 32'h0100_A8C0);
    for (int i = 0; i < N_ADDR; i++) begin
      drive_random_addresses();
      next_cycle();
    end
    report_test("address");

    $display("%0d tests, %0d checks, %0d errors.", tests, checks, errors);
    if (errors == 0) begin
      $display("TB PASSED");
    end else begin
      $display("TB FAILED");
    end
    $finish;
  end

endmodule

`default_nettype wire
